// ==== Makefile ====
TOP = la_analyser_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --assert --timescale 1ns/1ns -Wno-fatal -f flist.f --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Finished with no errors" sim.log

lint:
	verilator --lint-only --timing --assert -Wall -f flist.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

// ==== flist.f ====
+incdir+rtl
rtl/la_pkg.sv
rtl/la_wb_regs.sv
rtl/la_sample_ctrl.sv
rtl/la_sample_ram.sv
rtl/la_wave_display.sv
rtl/la_analyser_top.sv
verification/la_analyser_tb.sv

// ==== rtl/la_analyser_top.sv ====
`timescale 1ns/1ns
`include "la_defines.svh"

module la_analyser_top
   import la_pkg::*;
(
   input  logic                 pix_clk,
   input  logic                 sys_rst_n,
   input  logic                 i_wb_cyc,
   input  logic                 i_wb_stb,
   input  logic                 i_wb_we,
   input  logic [`LA_WB_AW-1:0] i_wb_adr,
   input  logic [`LA_WB_DW-1:0] i_wb_dat,
   output logic                 o_wb_ack,
   output logic [`LA_WB_DW-1:0] o_wb_dat,
   input  sample_t              i_probe,
   input  logic                 i_hs,
   input  logic                 i_vs,
   input  logic                 i_de,
   input  pixel_t               i_data,
   output logic                 o_hs,
   output logic                 o_vs,
   output logic                 o_de,
   output pixel_t               o_data,
   output logic                 o_finished
);

   // register outputs
   logic                 arm;
   trig_mode_t           trig_mode;
   logic [`LA_CHN_W-1:0] trig_chn;
   buf_addr_t            pre_num;
   div_t                 div;
   pixel_t               wave_color;

   // capture and buffer
   logic                 busy;
   buf_addr_t            start_addr;
   logic                 wr_en;
   buf_addr_t            wr_addr;
   sample_t              wr_data;
   buf_addr_t            rd_addr;
   sample_t              rd_data;

   la_wb_regs u_la_wb_regs (
      .pix_clk      (pix_clk),
      .sys_rst_n    (sys_rst_n),
      .i_wb_cyc     (i_wb_cyc),
      .i_wb_stb     (i_wb_stb),
      .i_wb_we      (i_wb_we),
      .i_wb_adr     (i_wb_adr),
      .i_wb_dat     (i_wb_dat),
      .i_finished   (o_finished),
      .i_busy       (busy),
      .i_start_addr (start_addr),
      .o_wb_ack     (o_wb_ack),
      .o_wb_dat     (o_wb_dat),
      .o_arm        (arm),
      .o_trig_mode  (trig_mode),
      .o_trig_chn   (trig_chn),
      .o_pre_num    (pre_num),
      .o_div        (div),
      .o_wave_color (wave_color)
   );

   la_sample_ctrl u_la_sample_ctrl (
      .pix_clk      (pix_clk),
      .sys_rst_n    (sys_rst_n),
      .i_probe      (i_probe),
      .i_arm        (arm),
      .i_trig_mode  (trig_mode),
      .i_trig_chn   (trig_chn),
      .i_pre_num    (pre_num),
      .i_div        (div),
      .o_wr_en      (wr_en),
      .o_wr_addr    (wr_addr),
      .o_wr_data    (wr_data),
      .o_start_addr (start_addr),
      .o_finished   (o_finished),
      .o_busy       (busy)
   );

   la_sample_ram u_la_sample_ram (
      .pix_clk   (pix_clk),
      .i_wr_en   (wr_en),
      .i_wr_addr (wr_addr),
      .i_wr_data (wr_data),
      .i_rd_addr (rd_addr),
      .o_rd_data (rd_data)
   );

   la_wave_display u_la_wave_display (
      .pix_clk      (pix_clk),
      .sys_rst_n    (sys_rst_n),
      .i_hs         (i_hs),
      .i_vs         (i_vs),
      .i_de         (i_de),
      .i_data       (i_data),
      .i_start_addr (start_addr),
      .i_wave_color (wave_color),
      .i_rd_data    (rd_data),
      .i_finished   (o_finished),
      .o_rd_addr    (rd_addr),
      .o_hs         (o_hs),
      .o_vs         (o_vs),
      .o_de         (o_de),
      .o_data       (o_data)
   );

endmodule

// ==== rtl/la_defines.svh ====
`ifndef LA_DEFINES_SVH
`define LA_DEFINES_SVH

//////////////////////////////
// capture buffer
//////////////////////////////
`define LA_CHANNELS    8                     // probe channels
`define LA_CHN_W       3                     // channel select width
`define LA_ADDR_W      10                    // buffer address bits
`define LA_DEPTH       (1 << `LA_ADDR_W)     // 1024 samples
`define LA_DIV_W       16
`define LA_PIX_W       24                    // rgb 8:8:8
`define LA_POS_W       12                    // pixel column / row counters

//////////////////////////////
// lane geometry
//////////////////////////////
`define LA_LANE_H      16                    // rows per lane
`define LA_OFF_W       4                     // row offset inside a lane
`define LA_HIGH_ROW    4'd2                  // level drawn for a 1
`define LA_LOW_ROW     4'd13                 // level drawn for a 0

//////////////////////////////
// wishbone register map
//////////////////////////////
`define LA_WB_AW       3
`define LA_WB_DW       32
`define LA_REG_CTRL    3'd0
`define LA_REG_PRE     3'd1
`define LA_REG_DIV     3'd2
`define LA_REG_STATUS  3'd3
`define LA_REG_START   3'd4
`define LA_REG_COLOR   3'd5
`define LA_COLOR_RST   24'hff0000            // red wave after reset

`endif

// ==== rtl/la_pkg.sv ====
`include "la_defines.svh"

package la_pkg;

   typedef logic [`LA_CHANNELS-1:0] sample_t;     // one sample of all probes
   typedef logic [`LA_ADDR_W-1:0]   buf_addr_t;   // capture buffer address
   typedef logic [`LA_PIX_W-1:0]    pixel_t;      // rgb pixel
   typedef logic [`LA_DIV_W-1:0]    div_t;        // sample divider

   // capture sequence, one pass per arm
   typedef enum logic [2:0] {
      CAP_IDLE      = 3'd0,
      CAP_PRE_FILL  = 3'd1,
      CAP_WAIT_TRIG = 3'd2,
      CAP_POST_FILL = 3'd3,
      CAP_DONE      = 3'd4
   } cap_state_t;

   // encoding of CTRL bits 2:1
   typedef enum logic [1:0] {
      TRIG_NONE = 2'd0,
      TRIG_RISE = 2'd1,
      TRIG_FALL = 2'd2
   } trig_mode_t;

endpackage

// ==== rtl/la_sample_ctrl.sv ====
`timescale 1ns/1ns
`include "la_defines.svh"

module la_sample_ctrl
   import la_pkg::*;
(
   input  logic                 pix_clk,
   input  logic                 sys_rst_n,
   input  sample_t              i_probe,
   input  logic                 i_arm,
   input  trig_mode_t           i_trig_mode,
   input  logic [`LA_CHN_W-1:0] i_trig_chn,
   input  buf_addr_t            i_pre_num,
   input  div_t                 i_div,
   output logic                 o_wr_en,
   output buf_addr_t            o_wr_addr,
   output sample_t              o_wr_data,
   output buf_addr_t            o_start_addr,
   output logic                 o_finished,
   output logic                 o_busy
);

   cap_state_t cap_state;
   div_t       div_cnt;
   logic       sampling;      // divider running, cleared on entry to done
   logic       tick;          // one sample slot
   buf_addr_t  wr_ptr;
   buf_addr_t  pre_cnt;       // pre-trigger samples stored
   buf_addr_t  post_left;     // samples still due after trigger
   sample_t    prev_sample;
   logic       prev_valid;
   logic       fill_pre;
   logic       cur_bit;
   logic       prev_bit;
   logic       trig_hit;

   assign o_busy     = (cap_state == CAP_PRE_FILL) || (cap_state == CAP_WAIT_TRIG) ||
                       (cap_state == CAP_POST_FILL);
   assign o_finished = (cap_state == CAP_DONE);
   assign tick       = sampling && (div_cnt == i_div);

   // every slot while sampling stores the probes
   assign o_wr_en   = tick;
   assign o_wr_addr = wr_ptr;
   assign o_wr_data = i_probe;

   //////////////////////////////
   // sample divider
   //////////////////////////////
   always_ff @(posedge pix_clk) begin
      if (!sys_rst_n) begin
         div_cnt <= '0;
      end else if (i_arm || tick || !sampling) begin
         div_cnt <= '0;   // restart so first tick lands div+1 after arm
      end else begin
         div_cnt <= div_cnt + 1'b1;
      end
   end

   //////////////////////////////
   // trigger detection
   //////////////////////////////
   assign cur_bit  = i_probe[i_trig_chn];
   assign prev_bit = prev_sample[i_trig_chn];
   assign fill_pre = (cap_state == CAP_PRE_FILL) && (pre_cnt != i_pre_num);

   always_comb begin
      case (i_trig_mode)
         TRIG_RISE: trig_hit = prev_valid && !prev_bit && cur_bit;
         TRIG_FALL: trig_hit = prev_valid && prev_bit && !cur_bit;
         default:   trig_hit = 1'b1;   // immediate
      endcase
   end

   always_ff @(posedge pix_clk) begin
      if (tick) begin
         prev_sample <= i_probe;   // last stored sample
      end
   end

   //////////////////////////////
   // capture FSM
   //////////////////////////////
   always_ff @(posedge pix_clk) begin
      if (!sys_rst_n) begin
         cap_state    <= CAP_IDLE;
         sampling     <= 1'b0;
         wr_ptr       <= '0;
         pre_cnt      <= '0;
         post_left    <= '0;
         prev_valid   <= 1'b0;
         o_start_addr <= '0;
      end else if (i_arm) begin
         cap_state  <= CAP_PRE_FILL;   // re-arm from any state
         sampling   <= 1'b1;
         wr_ptr     <= '0;
         pre_cnt    <= '0;
         prev_valid <= 1'b0;
      end else if (tick) begin
         wr_ptr     <= wr_ptr + 1'b1;
         prev_valid <= 1'b1;
         case (cap_state)
            CAP_PRE_FILL, CAP_WAIT_TRIG: begin
               if (fill_pre) begin
                  pre_cnt <= pre_cnt + 1'b1;
                  if (pre_cnt + 1'b1 == i_pre_num) begin
                     cap_state <= CAP_WAIT_TRIG;
                  end
               end else if (trig_hit) begin
                  // window opens pre samples before the trigger
                  o_start_addr <= wr_ptr - i_pre_num;
                  post_left    <= ~i_pre_num;   // 1023 - pre
                  if (&i_pre_num) begin
                     cap_state <= CAP_DONE;
                     sampling  <= 1'b0;
                  end else begin
                     cap_state <= CAP_POST_FILL;
                  end
               end else begin
                  cap_state <= CAP_WAIT_TRIG;   // pre = 0 lands here
               end
            end
            CAP_POST_FILL: begin
               post_left <= post_left - 1'b1;
               if (post_left == buf_addr_t'(1)) begin
                  cap_state <= CAP_DONE;
                  sampling  <= 1'b0;
               end
            end
            default: ;
         endcase
      end
   end

   wr_only_capturing: assert property (@(posedge pix_clk) disable iff (!sys_rst_n)
      o_wr_en |-> !(cap_state inside {CAP_IDLE, CAP_DONE}));

endmodule

// ==== rtl/la_sample_ram.sv ====
`timescale 1ns/1ns
`include "la_defines.svh"

module la_sample_ram
   import la_pkg::*;
(
   input  logic      pix_clk,
   input  logic      i_wr_en,
   input  buf_addr_t i_wr_addr,
   input  sample_t   i_wr_data,
   input  buf_addr_t i_rd_addr,
   output sample_t   o_rd_data
);

   sample_t mem [0:`LA_DEPTH-1];   // 1024 x 8

   // write port, capture side
   always_ff @(posedge pix_clk) begin
      if (i_wr_en) begin
         mem[i_wr_addr] <= i_wr_data;
      end
   end

   // read port, display side, one cycle latency
   always_ff @(posedge pix_clk) begin
      o_rd_data <= mem[i_rd_addr];
   end

endmodule

// ==== rtl/la_wave_display.sv ====
`timescale 1ns/1ns
`include "la_defines.svh"

module la_wave_display
   import la_pkg::*;
(
   input  logic      pix_clk,
   input  logic      sys_rst_n,
   input  logic      i_hs,
   input  logic      i_vs,
   input  logic      i_de,
   input  pixel_t    i_data,
   input  buf_addr_t i_start_addr,
   input  pixel_t    i_wave_color,
   input  sample_t   i_rd_data,
   input  logic      i_finished,
   output buf_addr_t o_rd_addr,
   output logic      o_hs,
   output logic      o_vs,
   output logic      o_de,
   output pixel_t    o_data
);

   logic [`LA_POS_W-1:0] x_cnt;   // column of current pixel
   logic [`LA_POS_W-1:0] y_cnt;   // row of current pixel
   logic                 de_d;
   logic                 vs_d;
   logic                 in_wave;

   logic                 s1_hs;
   logic                 s1_vs;
   logic                 s1_de;
   logic                 s1_in_wave;
   pixel_t               s1_data;
   logic [`LA_CHN_W-1:0] s1_lane;
   logic [`LA_OFF_W-1:0] s1_off;
   logic                 s1_x_nz;
   sample_t              prev_rd;   // sample at x-1
   logic                 cur_bit;
   logic                 prev_bit;
   logic                 on_high;
   logic                 on_low;
   logic                 on_bar;
   logic                 paint;

   //////////////////////////////
   // position counters
   //////////////////////////////
   always_ff @(posedge pix_clk) begin
      if (!sys_rst_n) begin
         x_cnt <= '0;
         y_cnt <= '0;
         de_d  <= 1'b0;
         vs_d  <= 1'b0;
      end else begin
         de_d <= i_de;
         vs_d <= i_vs;
         if (i_de) begin
            x_cnt <= x_cnt + 1'b1;
         end else begin
            x_cnt <= '0;   // back to column 0 in blanking
         end
         if (i_vs != vs_d) begin
            y_cnt <= '0;   // any vs edge starts a frame
         end else if (de_d && !i_de) begin
            y_cnt <= y_cnt + 1'b1;   // end of active line
         end
      end
   end

   assign o_rd_addr = i_start_addr + x_cnt[`LA_ADDR_W-1:0];   // wraps at 1024
   assign in_wave   = i_finished && i_de &&
                      (y_cnt < `LA_POS_W'(`LA_CHANNELS * `LA_LANE_H)) &&
                      (x_cnt < `LA_POS_W'(`LA_DEPTH));

   //////////////////////////////
   // stage 1, ram data arrives
   //////////////////////////////
   always_ff @(posedge pix_clk) begin
      if (!sys_rst_n) begin
         s1_hs      <= 1'b0;
         s1_vs      <= 1'b0;
         s1_de      <= 1'b0;
         s1_in_wave <= 1'b0;
      end else begin
         s1_hs      <= i_hs;
         s1_vs      <= i_vs;
         s1_de      <= i_de;
         s1_in_wave <= in_wave;
      end
   end

   always_ff @(posedge pix_clk) begin
      s1_data <= i_data;
      s1_lane <= y_cnt[`LA_OFF_W +: `LA_CHN_W];   // y / 16
      s1_off  <= y_cnt[`LA_OFF_W-1:0];
      s1_x_nz <= (x_cnt != '0);
      prev_rd <= i_rd_data;
   end

   assign cur_bit  = i_rd_data[s1_lane];
   assign prev_bit = prev_rd[s1_lane];
   assign on_high  = (s1_off == `LA_HIGH_ROW) && cur_bit;
   assign on_low   = (s1_off == `LA_LOW_ROW) && !cur_bit;
   // vertical edge between the two levels
   assign on_bar   = s1_x_nz && (cur_bit != prev_bit) &&
                     (s1_off >= `LA_HIGH_ROW) && (s1_off <= `LA_LOW_ROW);
   assign paint    = s1_in_wave && (on_high || on_low || on_bar);

   //////////////////////////////
   // stage 2, output
   //////////////////////////////
   always_ff @(posedge pix_clk) begin
      if (!sys_rst_n) begin
         o_hs <= 1'b0;
         o_vs <= 1'b0;
         o_de <= 1'b0;
      end else begin
         o_hs <= s1_hs;
         o_vs <= s1_vs;
         o_de <= s1_de;
      end
   end

   always_ff @(posedge pix_clk) begin
      o_data <= paint ? i_wave_color : s1_data;   // else pass video through
   end

endmodule

// ==== rtl/la_wb_regs.sv ====
`timescale 1ns/1ns
`include "la_defines.svh"

module la_wb_regs
   import la_pkg::*;
(
   input  logic                 pix_clk,
   input  logic                 sys_rst_n,
   input  logic                 i_wb_cyc,
   input  logic                 i_wb_stb,
   input  logic                 i_wb_we,
   input  logic [`LA_WB_AW-1:0] i_wb_adr,
   input  logic [`LA_WB_DW-1:0] i_wb_dat,
   input  logic                 i_finished,
   input  logic                 i_busy,
   input  buf_addr_t            i_start_addr,
   output logic                 o_wb_ack,
   output logic [`LA_WB_DW-1:0] o_wb_dat,
   output logic                 o_arm,
   output trig_mode_t           o_trig_mode,
   output logic [`LA_CHN_W-1:0] o_trig_chn,
   output buf_addr_t            o_pre_num,
   output div_t                 o_div,
   output pixel_t               o_wave_color
);

   logic                 wb_req;   // new access, not yet acked
   logic                 wb_wr;
   logic [`LA_WB_DW-1:0] rd_mux;

   assign wb_req = i_wb_cyc & i_wb_stb & ~o_wb_ack;
   assign wb_wr  = wb_req & i_wb_we;

   //////////////////////////////
   // classic cycle handshake
   //////////////////////////////
   always_ff @(posedge pix_clk) begin
      if (!sys_rst_n) begin
         o_wb_ack <= 1'b0;
      end else begin
         o_wb_ack <= wb_req;   // single cycle ack
      end
   end

   always_ff @(posedge pix_clk) begin
      if (wb_req) begin
         o_wb_dat <= rd_mux;   // valid together with ack
      end
   end

   //////////////////////////////
   // register writes
   //////////////////////////////
   always_ff @(posedge pix_clk) begin
      if (!sys_rst_n) begin
         o_arm        <= 1'b0;
         o_trig_mode  <= TRIG_NONE;
         o_trig_chn   <= '0;
         o_pre_num    <= '0;
         o_div        <= '0;
         o_wave_color <= `LA_COLOR_RST;
      end else begin
         o_arm <= wb_wr && (i_wb_adr == `LA_REG_CTRL) && i_wb_dat[0];   // self clearing
         if (wb_wr) begin
            case (i_wb_adr)
               `LA_REG_CTRL: begin
                  o_trig_mode <= trig_mode_t'(i_wb_dat[2:1]);
                  o_trig_chn  <= i_wb_dat[5:3];
               end
               `LA_REG_PRE:   o_pre_num    <= i_wb_dat[`LA_ADDR_W-1:0];
               `LA_REG_DIV:   o_div        <= i_wb_dat[`LA_DIV_W-1:0];
               `LA_REG_COLOR: o_wave_color <= i_wb_dat[`LA_PIX_W-1:0];
               default: ;   // STATUS and START are read only
            endcase
         end
      end
   end

   // readback
   always_comb begin
      case (i_wb_adr)
         `LA_REG_CTRL:   rd_mux = `LA_WB_DW'({o_trig_chn, o_trig_mode, 1'b0});
         `LA_REG_PRE:    rd_mux = `LA_WB_DW'(o_pre_num);
         `LA_REG_DIV:    rd_mux = `LA_WB_DW'(o_div);
         `LA_REG_STATUS: rd_mux = `LA_WB_DW'({i_busy, i_finished});
         `LA_REG_START:  rd_mux = `LA_WB_DW'(i_start_addr);
         `LA_REG_COLOR:  rd_mux = `LA_WB_DW'(o_wave_color);
         default:        rd_mux = '0;
      endcase
   end

   // master must hold cyc and stb until it sees ack
   ack_in_cycle: assert property (@(posedge pix_clk) disable iff (!sys_rst_n)
      o_wb_ack |-> (i_wb_cyc && i_wb_stb));

endmodule

// ==== verification/la_analyser_tb.sv ====
`timescale 1ns/1ns
`include "la_defines.svh"

module la_analyser_tb
   import la_pkg::*;
();

   localparam int N_ROWS    = 5;
   localparam int H_ACTIVE  = 1100;
   localparam int V_ACTIVE  = 140;
   localparam int ACK_LIMIT = 4;       // cycles allowed for a wishbone ack
   localparam int FIN_LIMIT = 20000;   // cycles allowed for a capture

   typedef struct packed {
      trig_mode_t           mode;
      logic [`LA_CHN_W-1:0] chn;
      buf_addr_t            pre;
      sample_t              pat_a;     // probes before the trigger
      sample_t              pat_b;     // probes from the trigger on
   } stim_row_t;

   typedef struct packed {
      logic [11:0] x;
      logic [11:0] y;
      logic [2:0]  sync;               // hs, vs, de
      pixel_t      data;
   } pix_exp_t;

   logic                 pix_clk;
   logic                 sys_rst_n;
   logic                 i_wb_cyc;
   logic                 i_wb_stb;
   logic                 i_wb_we;
   logic [`LA_WB_AW-1:0] i_wb_adr;
   logic [`LA_WB_DW-1:0] i_wb_dat;
   logic                 o_wb_ack;
   logic [`LA_WB_DW-1:0] o_wb_dat;
   sample_t              i_probe;
   logic                 i_hs;
   logic                 i_vs;
   logic                 i_de;
   pixel_t               i_data;
   logic                 o_hs;
   logic                 o_vs;
   logic                 o_de;
   pixel_t               o_data;
   logic                 o_finished;

   int       err_cnt     = 0;
   int       timeout_cnt = 0;
   int       seed        = 32'hfbf7e00d;
   int       div_val;
   int       cur_pre;
   sample_t  cur_a;
   sample_t  cur_b;
   pixel_t   color;
   logic     show_wave;                // capture on screen
   pix_exp_t exp_q [$];                // video out is two cycles behind

   stim_row_t stim_tbl [N_ROWS] = '{
      '{TRIG_RISE, 3'd3, 10'd100,  8'h35, 8'hca},   // many lanes flip at the trigger
      '{TRIG_FALL, 3'd6, 10'd512,  8'h4c, 8'h0d},
      '{TRIG_RISE, 3'd0, 10'd0,    8'hf0, 8'hf1},   // no pre-trigger part
      '{TRIG_FALL, 3'd7, 10'd1023, 8'h81, 8'h7e},   // trigger in last column
      '{TRIG_NONE, 3'd2, 10'd300,  8'ha5, 8'ha5}    // flat lanes
   };

   initial pix_clk = 1'b0;
   always #20 pix_clk = ~pix_clk;

   la_analyser_top la_analyser_top_inst (
      .pix_clk    (pix_clk),
      .sys_rst_n  (sys_rst_n),
      .i_wb_cyc   (i_wb_cyc),
      .i_wb_stb   (i_wb_stb),
      .i_wb_we    (i_wb_we),
      .i_wb_adr   (i_wb_adr),
      .i_wb_dat   (i_wb_dat),
      .o_wb_ack   (o_wb_ack),
      .o_wb_dat   (o_wb_dat),
      .i_probe    (i_probe),
      .i_hs       (i_hs),
      .i_vs       (i_vs),
      .i_de       (i_de),
      .i_data     (i_data),
      .o_hs       (o_hs),
      .o_vs       (o_vs),
      .o_de       (o_de),
      .o_data     (o_data),
      .o_finished (o_finished)
   );

   //////////////////////////////
   // wishbone master
   //////////////////////////////
   task automatic wb_access(input logic we, input logic [`LA_WB_AW-1:0] adr,
                            input logic [`LA_WB_DW-1:0] wdat,
                            output logic [`LA_WB_DW-1:0] rdat);
      int n;
      n    = 0;
      rdat = '0;
      if (timeout_cnt == 0) begin
         i_wb_cyc = 1'b1;
         i_wb_stb = 1'b1;
         i_wb_we  = we;
         i_wb_adr = adr;
         i_wb_dat = wdat;
         do begin
            @(posedge pix_clk);
            #2;
            n++;
         end while (!o_wb_ack && n < ACK_LIMIT);
         if (o_wb_ack) begin
            rdat = o_wb_dat;
            assert (n == 1) else begin
               $display("wishbone ack came %0d cycles after the request to %0d", n, adr);
               err_cnt++;
            end
            @(posedge pix_clk);   // master sees ack here
            #2;
            assert (!o_wb_ack) else begin
               $display("wishbone ack stayed high for more than one cycle");
               err_cnt++;
            end
         end else begin
            $display("timeout waiting for wishbone ack at address %0d", adr);
            timeout_cnt++;
         end
         i_wb_cyc = 1'b0;
         i_wb_stb = 1'b0;
         i_wb_we  = 1'b0;
      end
   endtask

   task automatic wb_write(input logic [`LA_WB_AW-1:0] adr, input logic [`LA_WB_DW-1:0] wdat);
      logic [`LA_WB_DW-1:0] unused;
      wb_access(1'b1, adr, wdat, unused);
   endtask

   task automatic wb_check(input logic [`LA_WB_AW-1:0] adr, input logic [`LA_WB_DW-1:0] want,
                           input string name);
      logic [`LA_WB_DW-1:0] got;
      wb_access(1'b0, adr, '0, got);
      if (timeout_cnt == 0) begin
         assert (got == want) else begin
            $display("FAILED %s: got %h, expected %h", name, got, want);
            err_cnt++;
         end
      end
   endtask

   // min_cycles counts edges from the call to the first one with finished high
   task automatic wait_finished(input int min_cycles);
      int n;
      n = 0;
      if (timeout_cnt == 0) begin
         while (!o_finished && n < FIN_LIMIT) begin
            @(posedge pix_clk);
            #2;
            n++;
         end
         if (!o_finished) begin
            $display("timeout waiting for the capture to finish");
            timeout_cnt++;
         end else begin
            assert (n >= min_cycles) else begin
               $display("capture finished after %0d cycles, before %0d", n, min_cycles);
               err_cnt++;
            end
         end
      end
   endtask

   //////////////////////////////
   // video model and checks
   //////////////////////////////
   function automatic pixel_t expected_pixel(input int x, input int y, input pixel_t din);
      int   lane;
      int   off;
      logic cur;
      logic prv;
      logic paint;
      if (!show_wave || y >= `LA_CHANNELS * `LA_LANE_H || x >= `LA_DEPTH) begin
         return din;
      end
      lane  = y / `LA_LANE_H;
      off   = y % `LA_LANE_H;
      cur   = (x < cur_pre) ? cur_a[lane] : cur_b[lane];
      prv   = (x - 1 < cur_pre) ? cur_a[lane] : cur_b[lane];   // column x-1
      paint = (off == `LA_HIGH_ROW && cur) || (off == `LA_LOW_ROW && !cur) ||
              (x > 0 && cur != prv && off >= `LA_HIGH_ROW && off <= `LA_LOW_ROW);
      return paint ? color : din;
   endfunction

   task automatic video_cycle(input logic hs, input logic vs, input logic de,
                              input int x, input int y);
      pix_exp_t want;
      pixel_t   din;
      if (exp_q.size() == 2) begin
         want = exp_q.pop_front();
         assert ({o_hs, o_vs, o_de} == want.sync) else begin
            $display("FAILED o_hs/o_vs/o_de at x=%0d y=%0d: got %h, expected %h",
                     want.x, want.y, {o_hs, o_vs, o_de}, want.sync);
            err_cnt++;
         end
         assert (o_data == want.data) else begin
            $display("FAILED o_data at x=%0d y=%0d: got %h, expected %h",
                     want.x, want.y, o_data, want.data);
            err_cnt++;
         end
      end
      din       = de ? {y[7:0], 4'h5, x[11:0]} : '0;   // row/column pattern
      want.x    = x[11:0];
      want.y    = y[11:0];
      want.sync = {hs, vs, de};
      want.data = de ? expected_pixel(x, y, din) : din;
      exp_q.push_back(want);
      i_hs   = hs;
      i_vs   = vs;
      i_de   = de;
      i_data = din;
      @(posedge pix_clk);
      #2;
   endtask

   task automatic run_frame(input logic wave);
      if (timeout_cnt == 0) begin
         show_wave = wave;
         for (int i = 0; i < 4; i++) begin
            video_cycle(1'b0, 1'b1, 1'b0, 0, 0);   // vs pulse
         end
         for (int y = 0; y < V_ACTIVE; y++) begin
            for (int i = 0; i < 12; i++) begin
               video_cycle(i < 4, 1'b0, 1'b0, 0, y);
            end
            for (int x = 0; x < H_ACTIVE; x++) begin
               video_cycle(1'b0, 1'b0, 1'b1, x, y);
            end
         end
         for (int i = 0; i < 4; i++) begin
            video_cycle(1'b0, 1'b0, 1'b0, 0, 0);
         end
         exp_q.delete();   // last two are blanking
      end
   endtask

   //////////////////////////////
   // main sequence
   //////////////////////////////
   initial begin
      stim_row_t row;
      int        hold;
      sys_rst_n = 1'b0;
      i_wb_cyc  = 1'b0;
      i_wb_stb  = 1'b0;
      i_wb_we   = 1'b0;
      i_wb_adr  = '0;
      i_wb_dat  = '0;
      i_probe   = '0;
      i_hs      = 1'b0;
      i_vs      = 1'b0;
      i_de      = 1'b0;
      i_data    = '0;
      show_wave = 1'b0;
      repeat (5) @(posedge pix_clk);
      #2;
      sys_rst_n = 1'b1;
      assert (!o_wb_ack && !o_finished) else begin
         $display("ack or finished is high after reset");
         err_cnt++;
      end
      wb_check(`LA_REG_COLOR, `LA_WB_DW'(`LA_COLOR_RST), "COLOR after reset");

      for (int r = 0; r < N_ROWS && timeout_cnt == 0; r++) begin
         row     = stim_tbl[r];
         div_val = $unsigned($random(seed)) % 4;
         cur_pre = int'(row.pre);
         cur_a   = row.pat_a;
         cur_b   = row.pat_b;
         color   = {4'(r), 4'h8, 16'hc03f};
         i_probe = row.pat_a;
         wb_write(`LA_REG_PRE, `LA_WB_DW'(row.pre));
         wb_write(`LA_REG_DIV, `LA_WB_DW'(div_val));
         wb_write(`LA_REG_COLOR, `LA_WB_DW'(color));
         wb_check(`LA_REG_PRE, `LA_WB_DW'(row.pre), "PRE");
         wb_check(`LA_REG_DIV, `LA_WB_DW'(div_val), "DIV");
         wb_check(`LA_REG_COLOR, `LA_WB_DW'(color), "COLOR");
         wb_write(`LA_REG_CTRL, `LA_WB_DW'({row.chn, row.mode, 1'b1}));   // arm
         wb_check(`LA_REG_STATUS, `LA_WB_DW'(2), "STATUS while busy");
         // the status read used two of the hold cycles
         hold = (cur_pre + 2) * (div_val + 1) - 2;
         repeat (hold) begin
            @(posedge pix_clk);
            #2;
         end
         i_probe = row.pat_b;   // trigger edge
         if (row.mode == TRIG_NONE) begin
            // trigger is the first slot after pre fill, two slots before the change
            wait_finished((1022 - cur_pre) * (div_val + 1));
         end else begin
            wait_finished((1024 - cur_pre) * (div_val + 1));
         end
         wb_check(`LA_REG_STATUS, `LA_WB_DW'(1), "STATUS when finished");
         run_frame(1'b1);
      end

      // armed again but the edge never comes, so video passes through
      i_probe = 8'h00;
      wb_write(`LA_REG_CTRL, `LA_WB_DW'({3'd0, TRIG_RISE, 1'b1}));
      wb_check(`LA_REG_STATUS, `LA_WB_DW'(2), "STATUS after re-arm");
      run_frame(1'b0);
      i_probe = 8'h01;
      // trigger lands on the next slot at the earliest
      wait_finished((1023 - cur_pre) * (div_val + 1) + 1);
      wb_check(`LA_REG_STATUS, `LA_WB_DW'(1), "STATUS after last capture");

      $display("errors: %0d, timeouts: %0d", err_cnt, timeout_cnt);
      if (err_cnt == 0 && timeout_cnt == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule
